//--- tests/icache_cases.txt
# op (F fetch, I interrupt, E fetch with bus error, A fetch plus interrupt)
# address or offset (hex), expected word (hex), expected bus transfers (decimal)
F 00000100 C0DE0100 16
F 00000104 C0DE0104 0
F 0000013C C0DE013C 0
F 00000200 C0DE0200 16
F 00000300 C0DE0300 16
F 00000400 C0DE0400 16
F 00000500 C0DE0500 16
F 00000600 C0DE0600 16
F 00000700 C0DE0700 16
F 00000800 C0DE0800 16
F 00000904 C0DE0904 16
F 00000108 C0DE0108 16
F 00000908 C0DE0908 0
F 00000102 00000000 0
E 00000A00 00000000 0
F 00000A10 C0DE0A10 16
F 00000A14 C0DE0A14 0
I 00000008 C0DE1008 1
I 0000003C C0DE103C 1
I 00000006 C0DE1004 1
A 00000C00 C0DE0C00 17
F 00000C04 C0DE0C04 0

//--- vlog.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_data_ram.sv
verilog/icache_refill.sv
verilog/icache_vector_fetch.sv
verilog/icache_bus_arbiter.sv
verilog/icache_top.sv
tests/icache_checker.sv
tests/icache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
RTL_TOP   ?= icache_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "simulation did not finish"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/icache_tb.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tb
  import icache_pkg::*;
;

  localparam string CASES_FILE = "tests/icache_cases.txt";
  // offset of the interrupt raised while a refill runs
  localparam logic [31:0] ARB_OFFSET = 32'h0000_0010;

  logic     clk_i;
  logic     reset_i;
  logic     fetch_req_i;
  word_t    fetch_addr_i;
  logic     fetch_ready_o;
  logic     instr_valid_o;
  word_t    instr_o;
  logic     instr_err_o;
  logic     irq_i;
  word_t    irq_offset_i;
  logic     irq_grant_o;
  logic     vector_valid_o;
  word_t    vector_pc_o;
  logic     vector_err_o;
  logic     bus_req_o;
  logic     bus_grant_i = 1'b0;
  logic     cyc_o;
  logic     stb_o;
  wb_addr_t adr_o;
  word_t    dat_i = '0;
  logic     ack_i = 1'b0;
  logic     err_i = 1'b0;

  // case bookkeeping handed to the checker
  logic        case_start;
  logic        case_done;
  logic [7:0]  case_op;
  int          case_idx;
  logic [31:0] exp_word;
  logic [31:0] exp_vec;
  int          exp_count;
  logic        exp_err;
  logic        arm_err;
  int          errors;
  int          passed;
  int          failed;

  logic [7:0]  op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] word_q[$];
  int          count_q[$];
  int          num_cases = 0;
  logic        cases_loaded = 1'b0;

  // memory model state
  logic [31:0] lfsr_q = 32'h665dbc4b;
  logic        ack_wait = 1'b0;
  logic [1:0]  ack_cnt = '0;
  logic        gnt_wait = 1'b0;
  logic [1:0]  gnt_cnt = '0;
  logic        err_used = 1'b0;

  icache_top icache_top_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_o  (fetch_ready_o),
    .instr_valid_o  (instr_valid_o),
    .instr_o        (instr_o),
    .instr_err_o    (instr_err_o),
    .irq_i          (irq_i),
    .irq_offset_i   (irq_offset_i),
    .irq_grant_o    (irq_grant_o),
    .vector_valid_o (vector_valid_o),
    .vector_pc_o    (vector_pc_o),
    .vector_err_o   (vector_err_o),
    .bus_req_o      (bus_req_o),
    .bus_grant_i    (bus_grant_i),
    .cyc_o          (cyc_o),
    .stb_o          (stb_o),
    .adr_o          (adr_o),
    .dat_i          (dat_i),
    .ack_i          (ack_i),
    .err_i          (err_i)
  );

  icache_checker checker_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_ready_i  (fetch_ready_o),
    .instr_valid_i  (instr_valid_o),
    .instr_i        (instr_o),
    .instr_err_i    (instr_err_o),
    .irq_grant_i    (irq_grant_o),
    .vector_valid_i (vector_valid_o),
    .vector_pc_i    (vector_pc_o),
    .vector_err_i   (vector_err_o),
    .bus_req_i      (bus_req_o),
    .cyc_i          (cyc_o),
    .stb_i          (stb_o),
    .ack_i          (ack_i),
    .err_i          (err_i),
    .case_start_i   (case_start),
    .case_done_i    (case_done),
    .case_op_i      (case_op),
    .case_idx_i     (case_idx),
    .exp_word_i     (exp_word),
    .exp_vec_i      (exp_vec),
    .exp_count_i    (exp_count),
    .exp_err_i      (exp_err),
    .errors_o       (errors),
    .passed_o       (passed),
    .failed_o       (failed)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  // galois lfsr stepped once per random bit
  function automatic logic next_bit();
    logic lsb;
    lsb = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic logic [1:0] rand2();
    logic [1:0] r;
    r[0] = next_bit();
    r[1] = next_bit();
    return r;
  endfunction

  // memory content is the byte address of the word xor a fixed pattern
  function automatic word_t mem_word(wb_addr_t a);
    return {a, 2'b00} ^ 32'hC0DE_0000;
  endfunction

  // wishbone slave and system arbiter with answers delayed 0 to 3 cycles
  always @(posedge clk_i) begin
    logic [1:0] d;
    logic       respond;
    respond = 1'b0;
    if (ack_i || err_i) begin
      ack_i <= 1'b0;
      err_i <= 1'b0;
    end else if (stb_o && cyc_o) begin
      if (!ack_wait) begin
        d = rand2();
        if (d == 2'd0) begin
          respond = 1'b1;
        end else begin
          ack_wait <= 1'b1;
          ack_cnt <= d - 2'd1;
        end
      end else if (ack_cnt == 2'd0) begin
        respond = 1'b1;
        ack_wait <= 1'b0;
      end else begin
        ack_cnt <= ack_cnt - 2'd1;
      end
    end
    if (respond) begin
      dat_i <= mem_word(adr_o);
      if (arm_err && !err_used) begin
        err_i <= 1'b1;
        err_used <= 1'b1;
      end else begin
        ack_i <= 1'b1;
      end
    end
    if (!arm_err) begin
      err_used <= 1'b0;
    end

    if (!bus_req_o) begin
      bus_grant_i <= 1'b0;
      gnt_wait <= 1'b0;
    end else if (!bus_grant_i) begin
      if (!gnt_wait) begin
        d = rand2();
        if (d == 2'd0) begin
          bus_grant_i <= 1'b1;
        end else begin
          gnt_wait <= 1'b1;
          gnt_cnt <= d - 2'd1;
        end
      end else if (gnt_cnt == 2'd0) begin
        bus_grant_i <= 1'b1;
        gnt_wait <= 1'b0;
      end else begin
        gnt_cnt <= gnt_cnt - 2'd1;
      end
    end
  end

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    string       op;
    logic [31:0] a;
    logic [31:0] w;
    int          c;
    fd = $fopen(CASES_FILE, "r");
    if (fd == 0) begin
      $display("could not open the cases file %s", CASES_FILE);
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != 8'h23) begin
          n = $sscanf(line, "%s %h %h %d", op, a, w, c);
          if (n == 4) begin
            op_q.push_back(op.getc(0));
            addr_q.push_back(a);
            word_q.push_back(w);
            count_q.push_back(c);
          end
        end
      end
      $fclose(fd);
      num_cases = op_q.size();
    end
  endtask

  task automatic request_fetch(word_t addr);
    fetch_req_i <= 1'b1;
    fetch_addr_i <= addr;
    do @(posedge clk_i); while (!fetch_ready_o);
    fetch_req_i <= 1'b0;
  endtask

  task automatic raise_irq(word_t offset);
    irq_i <= 1'b1;
    irq_offset_i <= offset;
    do @(posedge clk_i); while (!irq_grant_o);
    irq_i <= 1'b0;
  endtask

  task automatic run_case(int idx);
    logic        got_instr;
    logic        got_vec;
    logic [31:0] vbyte;
    got_instr = 1'b0;
    got_vec = 1'b0;
    vbyte = `ICACHE_VTABLE_BASE + ARB_OFFSET;
    @(posedge clk_i);
    case_start <= 1'b1;
    case_idx <= idx;
    case_op <= op_q[idx];
    exp_word <= word_q[idx];
    exp_count <= count_q[idx];
    exp_err <= (op_q[idx] == "E") || (op_q[idx] != "I" && addr_q[idx][1:0] != 2'b00);
    exp_vec <= (op_q[idx] == "A") ? mem_word(vbyte[31:2]) : word_q[idx];
    arm_err <= (op_q[idx] == "E");
    @(posedge clk_i);
    case_start <= 1'b0;
    if (op_q[idx] == "I") begin
      raise_irq(addr_q[idx]);
      do @(posedge clk_i); while (!vector_valid_o);
    end else if (op_q[idx] == "A") begin
      request_fetch(addr_q[idx]);
      // raise the interrupt once the refill holds the bus
      do @(posedge clk_i); while (!cyc_o);
      raise_irq(ARB_OFFSET);
      while (!(got_instr && got_vec)) begin
        @(posedge clk_i);
        if (instr_valid_o) begin
          got_instr = 1'b1;
        end
        if (vector_valid_o) begin
          got_vec = 1'b1;
        end
      end
    end else begin
      request_fetch(addr_q[idx]);
      do @(posedge clk_i); while (!instr_valid_o);
    end
    case_done <= 1'b1;
    arm_err <= 1'b0;
    @(posedge clk_i);
    case_done <= 1'b0;
  endtask

  initial begin
    reset_i = 1'b1;
    fetch_req_i = 1'b0;
    fetch_addr_i = '0;
    irq_i = 1'b0;
    irq_offset_i = '0;
    case_start = 1'b0;
    case_done = 1'b0;
    case_op = 8'h00;
    case_idx = 0;
    exp_word = '0;
    exp_vec = '0;
    exp_count = 0;
    exp_err = 1'b0;
    arm_err = 1'b0;
    load_cases();
    cases_loaded = 1'b1;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    for (int i = 0; i < num_cases; i++) begin
      run_case(i);
    end
    repeat (2) @(posedge clk_i);
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             num_cases, passed, failed, errors);
    if (errors == 0 && num_cases > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog sized from the number of cases
  initial begin
    wait (cases_loaded);
    repeat ((num_cases + 1) * 200) @(posedge clk_i);
    $display("timeout: the tests did not finish within %0d cycles", (num_cases + 1) * 200);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- tests/icache_checker.sv
`timescale 1ns/1ps

module icache_checker
  import icache_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        fetch_req_i,
  input  logic        fetch_ready_i,
  input  logic        instr_valid_i,
  input  word_t       instr_i,
  input  logic        instr_err_i,
  input  logic        irq_grant_i,
  input  logic        vector_valid_i,
  input  word_t       vector_pc_i,
  input  logic        vector_err_i,
  input  logic        bus_req_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        ack_i,
  input  logic        err_i,
  input  logic        case_start_i,
  input  logic        case_done_i,
  input  logic [7:0]  case_op_i,
  input  int          case_idx_i,
  input  logic [31:0] exp_word_i,
  input  logic [31:0] exp_vec_i,
  input  int          exp_count_i,
  input  logic        exp_err_i,
  output int          errors_o,
  output int          passed_o,
  output int          failed_o
);

  int    cycle = 0;
  int    xfers = 0;
  int    grants = 0;
  int    acc_cycle = 0;
  int    lat = 0;
  int    instr_seen = 0;
  int    vec_seen = 0;
  int    err_base = 0;
  word_t instr_val = '0;
  logic  instr_e = 1'b0;
  word_t vec_val = '0;
  logic  vec_e = 1'b0;
  logic  pend_q = 1'b0;

  initial begin
    errors_o = 0;
    passed_o = 0;
    failed_o = 0;
  end

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors_o++;
    end
  endtask

  task automatic evaluate();
    logic is_fetch;
    logic is_irq;
    is_fetch = (case_op_i == "F") || (case_op_i == "E") || (case_op_i == "A");
    is_irq = (case_op_i == "I") || (case_op_i == "A");
    if (is_fetch) begin
      if (instr_seen != 1) begin
        $display("test %0d saw %0d instruction responses instead of one", case_idx_i, instr_seen);
        errors_o++;
      end else begin
        check_value("instr_err_o", 32'(exp_err_i), 32'(instr_e));
        if (!exp_err_i) begin
          check_value("instr_o", exp_word_i, instr_val);
        end
        // misaligned fetches answer after 1 cycle and hits after 2
        if (case_op_i == "F" && exp_err_i) begin
          check_value("fetch latency", 32'd1, 32'(lat));
        end else if (case_op_i == "F" && exp_count_i == 0) begin
          check_value("hit latency", 32'd2, 32'(lat));
        end
      end
    end
    if (is_irq) begin
      if (vec_seen != 1) begin
        $display("test %0d saw %0d vector responses instead of one", case_idx_i, vec_seen);
        errors_o++;
      end else begin
        check_value("vector_err_o", 32'd0, 32'(vec_e));
        check_value("vector_pc_o", exp_vec_i, vec_val);
      end
      check_value("irq_grant_o pulses", 32'd1, 32'(grants));
    end
    check_value("bus transfers", 32'(exp_count_i), 32'(xfers));
    // the system bus is released once every engine has answered
    check_value("bus_req_o", 32'd0, 32'(bus_req_i));
    if (errors_o == err_base) begin
      passed_o++;
      $display("test %0d op %s: ok, %0d transfers", case_idx_i, case_op_i, xfers);
    end else begin
      failed_o++;
      $display("test %0d op %s: failed", case_idx_i, case_op_i);
    end
  endtask

  always @(posedge clk_i) begin
    cycle++;
    // idle values once reset has been seen at an edge
    if (reset_i && cycle > 1) begin
      check_value("fetch_ready_o", 32'd1, 32'(fetch_ready_i));
      check_value("instr_valid_o", 32'd0, 32'(instr_valid_i));
      check_value("vector_valid_o", 32'd0, 32'(vector_valid_i));
      check_value("irq_grant_o", 32'd0, 32'(irq_grant_i));
      check_value("bus_req_o", 32'd0, 32'(bus_req_i));
      check_value("cyc_o", 32'd0, 32'(cyc_i));
      check_value("stb_o", 32'd0, 32'(stb_i));
    end
    // a strobe left unanswered must keep its cycle
    if (!reset_i && pend_q && !cyc_i) begin
      $display("at %0t ns cyc_o dropped while a transfer was still waiting", $time);
      errors_o++;
    end
    pend_q <= !reset_i && stb_i && !ack_i && !err_i;
    if (case_start_i) begin
      xfers = 0;
      grants = 0;
      instr_seen = 0;
      vec_seen = 0;
      acc_cycle = cycle;
      err_base = errors_o;
    end else begin
      if (stb_i && ack_i) begin
        xfers++;
      end
      if (irq_grant_i) begin
        grants++;
      end
      if (fetch_req_i && fetch_ready_i) begin
        acc_cycle = cycle;
      end
      if (instr_valid_i) begin
        instr_seen++;
        instr_val = instr_i;
        instr_e = instr_err_i;
        lat = cycle - acc_cycle;
      end
      if (vector_valid_i) begin
        vec_seen++;
        vec_val = vector_pc_i;
        vec_e = vector_err_i;
      end
    end
    if (case_done_i) begin
      evaluate();
    end
  end

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     fetch_req_i,
  input  word_t    fetch_addr_i,
  output logic     fetch_ready_o,
  output logic     instr_valid_o,
  output word_t    instr_o,
  output logic     instr_err_o,
  input  logic     irq_i,
  input  word_t    irq_offset_i,
  output logic     irq_grant_o,
  output logic     vector_valid_o,
  output word_t    vector_pc_o,
  output logic     vector_err_o,
  output logic     bus_req_o,
  input  logic     bus_grant_i,
  output logic     cyc_o,
  output logic     stb_o,
  output wb_addr_t adr_o,
  input  word_t    dat_i,
  input  logic     ack_i,
  input  logic     err_i
);

  logic      ram_we;
  ram_addr_t ram_waddr;
  ram_addr_t ram_raddr;

  logic      refill_req;
  logic      refill_gnt;
  logic      refill_stb;
  wb_addr_t  refill_adr;
  logic      refill_ack;
  logic      refill_err;

  logic      vector_req;
  logic      vector_gnt;
  logic      vector_stb;
  wb_addr_t  vector_adr;
  logic      vector_ack;
  logic      vector_err;

  // refill data lands straight from the bus, hits read it back
  icache_data_ram icache_data_ram_i (
    .clk_i   (clk_i),
    .we_i    (ram_we),
    .waddr_i (ram_waddr),
    .wdata_i (dat_i),
    .raddr_i (ram_raddr),
    .rdata_o (instr_o)
  );

  icache_refill icache_refill_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_o (fetch_ready_o),
    .instr_valid_o (instr_valid_o),
    .instr_err_o   (instr_err_o),
    .ram_we_o      (ram_we),
    .ram_waddr_o   (ram_waddr),
    .ram_raddr_o   (ram_raddr),
    .bus_req_o     (refill_req),
    .bus_gnt_i     (refill_gnt),
    .bus_stb_o     (refill_stb),
    .bus_adr_o     (refill_adr),
    .bus_ack_i     (refill_ack),
    .bus_err_i     (refill_err)
  );

  icache_vector_fetch icache_vector_fetch_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .irq_i          (irq_i),
    .irq_offset_i   (irq_offset_i),
    .irq_grant_o    (irq_grant_o),
    .vector_valid_o (vector_valid_o),
    .vector_pc_o    (vector_pc_o),
    .vector_err_o   (vector_err_o),
    .bus_req_o      (vector_req),
    .bus_gnt_i      (vector_gnt),
    .bus_stb_o      (vector_stb),
    .bus_adr_o      (vector_adr),
    .bus_ack_i      (vector_ack),
    .bus_err_i      (vector_err),
    .bus_dat_i      (dat_i)
  );

  icache_bus_arbiter icache_bus_arbiter_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .refill_req_i (refill_req),
    .refill_stb_i (refill_stb),
    .refill_adr_i (refill_adr),
    .refill_gnt_o (refill_gnt),
    .refill_ack_o (refill_ack),
    .refill_err_o (refill_err),
    .vector_req_i (vector_req),
    .vector_stb_i (vector_stb),
    .vector_adr_i (vector_adr),
    .vector_gnt_o (vector_gnt),
    .vector_ack_o (vector_ack),
    .vector_err_o (vector_err),
    .bus_req_o    (bus_req_o),
    .bus_grant_i  (bus_grant_i),
    .cyc_o        (cyc_o),
    .stb_o        (stb_o),
    .adr_o        (adr_o),
    .ack_i        (ack_i),
    .err_i        (err_i)
  );

endmodule

//--- verilog/icache_bus_arbiter.sv
`timescale 1ns/1ps

module icache_bus_arbiter
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     refill_req_i,
  input  logic     refill_stb_i,
  input  wb_addr_t refill_adr_i,
  output logic     refill_gnt_o,
  output logic     refill_ack_o,
  output logic     refill_err_o,
  input  logic     vector_req_i,
  input  logic     vector_stb_i,
  input  wb_addr_t vector_adr_i,
  output logic     vector_gnt_o,
  output logic     vector_ack_o,
  output logic     vector_err_o,
  output logic     bus_req_o,
  input  logic     bus_grant_i,
  output logic     cyc_o,
  output logic     stb_o,
  output wb_addr_t adr_o,
  input  logic     ack_i,
  input  logic     err_i
);

  logic own_refill_q;
  logic own_vector_q;

  // owner register, vector wins a tie and is never preempted
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      own_refill_q <= 1'b0;
      own_vector_q <= 1'b0;
    end else if (!own_refill_q && !own_vector_q) begin
      if (bus_grant_i && vector_req_i) begin
        own_vector_q <= 1'b1;
      end else if (bus_grant_i && refill_req_i) begin
        own_refill_q <= 1'b1;
      end
    end else if (own_refill_q && !refill_req_i) begin
      own_refill_q <= 1'b0;
    end else if (own_vector_q && !vector_req_i) begin
      own_vector_q <= 1'b0;
    end
  end

  assign bus_req_o = refill_req_i || vector_req_i;

  assign refill_gnt_o = own_refill_q;
  assign vector_gnt_o = own_vector_q;

  assign cyc_o = own_refill_q || own_vector_q;
  assign stb_o = (own_refill_q && refill_stb_i) || (own_vector_q && vector_stb_i);
  assign adr_o = own_vector_q ? vector_adr_i : refill_adr_i;

  // results go back to the owner only
  assign refill_ack_o = own_refill_q && ack_i;
  assign refill_err_o = own_refill_q && err_i;
  assign vector_ack_o = own_vector_q && ack_i;
  assign vector_err_o = own_vector_q && err_i;

  arb_one_owner_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(refill_gnt_o && vector_gnt_o));

endmodule

//--- verilog/icache_vector_fetch.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_vector_fetch
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     irq_i,
  input  word_t    irq_offset_i,
  output logic     irq_grant_o,
  output logic     vector_valid_o,
  output word_t    vector_pc_o,
  output logic     vector_err_o,
  output logic     bus_req_o,
  input  logic     bus_gnt_i,
  output logic     bus_stb_o,
  output wb_addr_t bus_adr_o,
  input  logic     bus_ack_i,
  input  logic     bus_err_i,
  input  word_t    bus_dat_i
);

  typedef enum logic [1:0] {
    VS_IDLE,
    VS_REQ,
    VS_READ,
    VS_DONE
  } state_e;

  state_e   state_q;
  logic     err_q;
  wb_addr_t adr_q;
  word_t    pc_q;
  word_t    entry_addr;

  // table entry byte address, low two bits dropped below
  assign entry_addr = `ICACHE_VTABLE_BASE + irq_offset_i;

  assign irq_grant_o = (state_q == VS_IDLE) && irq_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= VS_IDLE;
      err_q <= 1'b0;
    end else begin
      case (state_q)
        VS_IDLE: begin
          if (irq_grant_o) begin
            state_q <= VS_REQ;
          end
        end
        VS_REQ: begin
          if (bus_gnt_i) begin
            state_q <= VS_READ;
          end
        end
        VS_READ: begin
          if (bus_ack_i || bus_err_i) begin
            err_q <= bus_err_i;
            state_q <= VS_DONE;
          end
        end
        default: begin
          state_q <= VS_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (irq_grant_o) begin
      adr_q <= entry_addr[`ICACHE_WORD_BITS-1:2];
    end
    if ((state_q == VS_READ) && bus_ack_i) begin
      pc_q <= bus_dat_i;
    end
  end

  assign bus_req_o = (state_q == VS_REQ) || (state_q == VS_READ);
  assign bus_stb_o = (state_q == VS_READ);
  assign bus_adr_o = adr_q;

  assign vector_valid_o = (state_q == VS_DONE);
  assign vector_err_o = vector_valid_o && err_q;
  assign vector_pc_o = pc_q;

  // a second interrupt waits until the running lookup has answered
  vector_grant_idle_a: assert property (@(posedge clk_i) disable iff (reset_i)
    irq_grant_o |=> !irq_grant_o);

endmodule

//--- verilog/icache_refill.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_refill
  import icache_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      fetch_req_i,
  input  word_t     fetch_addr_i,
  output logic      fetch_ready_o,
  output logic      instr_valid_o,
  output logic      instr_err_o,
  output logic      ram_we_o,
  output ram_addr_t ram_waddr_o,
  output ram_addr_t ram_raddr_o,
  output logic      bus_req_o,
  input  logic      bus_gnt_i,
  output logic      bus_stb_o,
  output wb_addr_t  bus_adr_o,
  input  logic      bus_ack_i,
  input  logic      bus_err_i
);

  localparam int unsigned NUM_LINES = 1 << `ICACHE_INDEX_BITS;
  localparam int unsigned TAG_LSB = `ICACHE_LINE_BITS + 2;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_REQ,
    ST_READ,
    ST_RESP
  } state_e;

  state_e               state_q;
  logic                 err_q;
  word_off_t            word_cnt_q;
  line_idx_t            victim_q;
  logic [NUM_LINES-1:0] tag_valid_q;
  tag_t                 tags_q [NUM_LINES];
  tag_t                 addr_tag_q;
  word_off_t            addr_off_q;
  logic                 accept;
  logic                 misaligned;
  logic                 last_word;
  logic                 hit;
  line_idx_t            hit_idx;

  assign accept = fetch_req_i && fetch_ready_o;
  assign misaligned = |fetch_addr_i[1:0];
  assign last_word = (state_q == ST_READ) && bus_ack_i && !bus_err_i && (&word_cnt_q);

  // compare the captured tag against every line
  always_comb begin
    hit = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < NUM_LINES; i++) begin
      if (tag_valid_q[i] && (tags_q[i] == addr_tag_q)) begin
        hit = 1'b1;
        hit_idx = line_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      err_q <= 1'b0;
      word_cnt_q <= '0;
      victim_q <= '0;
      tag_valid_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE, ST_RESP: begin
          if (accept) begin
            err_q <= misaligned;
            state_q <= misaligned ? ST_RESP : ST_LOOKUP;
          end else begin
            state_q <= ST_IDLE;
          end
        end
        ST_LOOKUP: begin
          if (hit) begin
            state_q <= ST_RESP;
          end else begin
            // the victim goes invalid before its words are overwritten
            tag_valid_q[victim_q] <= 1'b0;
            word_cnt_q <= '0;
            state_q <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (bus_gnt_i) begin
            state_q <= ST_READ;
          end
        end
        ST_READ: begin
          if (bus_err_i) begin
            err_q <= 1'b1;
            state_q <= ST_RESP;
          end else if (bus_ack_i) begin
            word_cnt_q <= word_cnt_q + 1'b1;
            if (last_word) begin
              tag_valid_q[victim_q] <= 1'b1;
              victim_q <= victim_q + 1'b1;
              // back to the lookup, which now hits
              state_q <= ST_LOOKUP;
            end
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_tag_q <= fetch_addr_i[`ICACHE_WORD_BITS-1:TAG_LSB];
      addr_off_q <= fetch_addr_i[TAG_LSB-1:2];
    end
    if (last_word) begin
      tags_q[victim_q] <= addr_tag_q;
    end
  end

  assign fetch_ready_o = (state_q == ST_IDLE) || (state_q == ST_RESP);
  assign instr_valid_o = (state_q == ST_RESP);
  assign instr_err_o = instr_valid_o && err_q;

  assign ram_we_o = (state_q == ST_READ) && bus_ack_i && !bus_err_i;
  assign ram_waddr_o = {victim_q, word_cnt_q};
  assign ram_raddr_o = {hit_idx, addr_off_q};

  assign bus_req_o = (state_q == ST_REQ) || (state_q == ST_READ);
  assign bus_stb_o = (state_q == ST_READ);
  assign bus_adr_o = {addr_tag_q, word_cnt_q};

  // a waiting strobe keeps its address until the slave answers
  refill_adr_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    bus_stb_o && !bus_ack_i && !bus_err_i |=> bus_stb_o && $stable(bus_adr_o));

  // a refill only hands back the fetch port through a bus error or the final lookup
  refill_no_ready_a: assert property (@(posedge clk_i) disable iff (reset_i)
    bus_req_o && !bus_err_i |=> !fetch_ready_o);

endmodule

//--- verilog/icache_data_ram.sv
`timescale 1ns/1ps

module icache_data_ram
  import icache_pkg::*;
(
  input  logic      clk_i,
  input  logic      we_i,
  input  ram_addr_t waddr_i,
  input  word_t     wdata_i,
  input  ram_addr_t raddr_i,
  output word_t     rdata_o
);

  localparam int unsigned DEPTH = 1 << $bits(ram_addr_t);

  word_t mem_q [DEPTH];

  // refill side, one word per bus ack
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // registered read, data shows up the cycle after the address
  always_ff @(posedge clk_i) begin
    rdata_o <= mem_q[raddr_i];
  end

endmodule

//--- verilog/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

  // one instruction or bus data word
  typedef logic [`ICACHE_WORD_BITS-1:0] word_t;

  // Wishbone word address, byte offset dropped
  typedef logic [`ICACHE_WORD_BITS-3:0] wb_addr_t;

  // upper address bits that name a line in memory
  typedef logic [`ICACHE_WORD_BITS-3-`ICACHE_LINE_BITS:0] tag_t;

  // cache line number
  typedef logic [`ICACHE_INDEX_BITS-1:0] line_idx_t;

  // word inside a line
  typedef logic [`ICACHE_LINE_BITS-1:0] word_off_t;

  // instruction RAM address, line number then word
  typedef logic [`ICACHE_INDEX_BITS+`ICACHE_LINE_BITS-1:0] ram_addr_t;

endpackage

//--- verilog/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// instruction word and Wishbone data width
`define ICACHE_WORD_BITS 32

// log2 of words per cache line, 16 words
`define ICACHE_LINE_BITS 4

// log2 of line count, 8 fully associative lines
`define ICACHE_INDEX_BITS 3

// byte address where the interrupt vector table starts
`define ICACHE_VTABLE_BASE 32'h0000_1000

`endif
